/* flist.f */
+incdir+dv
hw/console_pkg.sv
hw/screen_buffer.sv
hw/teletype.sv
hw/status_scanner.sv
hw/status_console.sv
dv/tb_status_console.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the status console testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_status_console
LOG=sim.log

verilator --binary --assert -f flist.f --top-module tb_status_console \
   --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1

/* dv/tb_console_tests.svh */
// --------------------
// Expected screen text
// --------------------
function automatic string letter_or_blank(logic set, string letter);
   if (set)
      return letter;
   return " ";
endfunction

function automatic string hex_byte(logic [7:0] v);
   string digits;
   digits = "0123456789ABCDEF";
   return $sformatf("%c%c", digits[v[7:4]], digits[v[3:0]]);
endfunction

function automatic string pad_a_text(pad_state_t p, logic snes);
   string tag;
   tag = snes ? "SNES" : "    ";
   return {letter_or_blank(p.up, "U"), letter_or_blank(p.down, "D"),
           letter_or_blank(p.left, "L"), letter_or_blank(p.right, "R"),
           letter_or_blank(p.a, "A"), letter_or_blank(p.b, "B"),
           letter_or_blank(p.c, "C"), " ", tag};
endfunction

function automatic string pad_b_text(pad_state_t p);
   return {letter_or_blank(p.x, "X"), letter_or_blank(p.y, "Y"),
           letter_or_blank(p.z, "Z"), " ",
           letter_or_blank(p.start, "S"), letter_or_blank(p.mode, "M")};
endfunction

function automatic string mem_text(mem_test_t t);
   if (t.in_progress)
      return "wait ";   // Wins over passed
   if (t.passed)
      return "OK   ";
   return "ERROR";
endfunction

function automatic string mouse_text(mouse_state_t m);
   return {hex_byte(m.x), " ", hex_byte(m.y), " ",
           letter_or_blank(m.buttons.left, "L"),
           letter_or_blank(m.buttons.middle, "M"),
           letter_or_blank(m.buttons.right, "R")};
endfunction

function automatic string field_text(logic [4:0] row);
   case (row)
      ROW_PAD1_A: return pad_a_text(pad1, pad1_snes);
      ROW_PAD1_B: return pad_b_text(pad1);
      ROW_PAD2_A: return pad_a_text(pad2, pad2_snes);
      ROW_PAD2_B: return pad_b_text(pad2);
      ROW_SRAM:   return mem_text(sram_test);
      ROW_SDRAM:  return mem_text(sdram_test);
      ROW_SD:     return mem_text(sd_test);
      ROW_MOUSE:  return mouse_text(mouse);
      default:    return "";
   endcase
endfunction

function automatic logic [7:0] expected_cell(int row, int col);
   string text;
   int    pos;
   text = field_text(5'(row));
   pos  = col - int'(FIELD_COL);
   if (pos >= 0 && pos < text.len())
      return text[pos];
   return CHAR_BLANK;   // Left blank by HOME
endfunction

// --------------------
// Directed tests
// --------------------
task automatic clear_after_reset();
   wait_passes(1);
   check_rows("clear", 0, SCREEN_ROWS - 1);
endtask

task automatic pad1_fields();
   logic [31:0] bits;
   for (int i = 0; i < 4; i++) begin
      bits = random_bits(12);
      @(negedge clk);
      pad1      = bits[11:0];
      pad1_snes = i[0];
      wait_passes(2);
      check_rows("pad1", int'(ROW_PAD1_A), int'(ROW_PAD2_B));
   end
endtask

task automatic pad2_fields();
   logic [31:0] bits;
   for (int i = 0; i < 4; i++) begin
      bits = random_bits(12);
      @(negedge clk);
      pad2      = bits[11:0];
      pad2_snes = ~i[0];
      wait_passes(2);
      check_rows("pad2", int'(ROW_PAD1_A), int'(ROW_PAD2_B));  // Pad 1 rows held
   end
endtask

task automatic mouse_field();
   logic [31:0] bits;
   for (int i = 0; i < 4; i++) begin
      bits = random_bits(19);
      @(negedge clk);
      mouse = bits[18:0];
      wait_passes(2);
      check_rows("mouse", int'(ROW_MOUSE), int'(ROW_MOUSE));
   end
endtask

task automatic memory_status();
   mem_test_t states [3];
   states = '{2'b00, 2'b11, 2'b01};   // Neither, progress with passed, passed only
   for (int m = 0; m < 3; m++) begin
      for (int s = 0; s < 3; s++) begin
         @(negedge clk);
         case (m)
            0:       sram_test  = states[s];
            1:       sdram_test = states[s];
            default: sd_test    = states[s];
         endcase
         wait_passes(2);
         check_rows("memory", int'(ROW_SRAM), int'(ROW_SD));
      end
   end
endtask

/* dv/tb_status_console.sv */
`timescale 1ns/10ps

module tb_status_console
   import console_pkg::*;
();

   localparam int PASS_CYCLES  = 1500;
   localparam int TEST_STEPS   = 22;   // Input changes over all tests
   localparam int LIMIT_CYCLES = TEST_STEPS * PASS_CYCLES * 3;

   logic                   clk;
   logic                   rst_n;
   pad_state_t             pad1;
   pad_state_t             pad2;
   logic                   pad1_snes;
   logic                   pad2_snes;
   mouse_state_t           mouse;
   mem_test_t              sram_test;
   mem_test_t              sdram_test;
   mem_test_t              sd_test;
   logic [CELL_ADDR_W-1:0] read_addr;
   logic [7:0]             read_data;
   logic                   pass_done;

   int          error_count;
   int          check_count;
   logic [31:0] lfsr;

   status_console i_status_console (
      .clk        (clk),
      .rst_n      (rst_n),
      .pad1       (pad1),
      .pad2       (pad2),
      .pad1_snes  (pad1_snes),
      .pad2_snes  (pad2_snes),
      .mouse      (mouse),
      .sram_test  (sram_test),
      .sdram_test (sdram_test),
      .sd_test    (sd_test),
      .read_addr  (read_addr),
      .read_data  (read_data),
      .pass_done  (pass_done)
   );

   always #5 clk = ~clk;

   // --------------------
   // Helpers
   // --------------------
   function automatic logic lfsr_next_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // x^32 + x^22 + x^2 + x + 1
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] random_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], lfsr_next_bit()};
      return v;
   endfunction

   task automatic check_value(input string test, input logic [7:0] expected,
                              input logic [7:0] actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("ERROR %s: expected %h '%c', actual %h '%c'",
                  test, expected, expected, actual, actual);
      end
   endtask

   task automatic read_cell(input int row, input int col, output logic [7:0] data);
      @(negedge clk);
      read_addr = CELL_ADDR_W'(row * SCREEN_COLS + col);
      @(negedge clk);   // Registered read port
      data = read_data;
   endtask

   task automatic wait_passes(input int n);
      int seen;
      seen = 0;
      while (seen < n) begin
         @(negedge clk);
         if (pass_done) begin
            seen++;
            @(negedge clk);
            check_value("pass_done pulse", 8'h00, 8'(pass_done));  // One cycle wide
         end
      end
   endtask

   task automatic check_rows(input string test, input int first, input int last);
      logic [7:0] data;
      for (int row = first; row <= last; row++) begin
         for (int col = 0; col < SCREEN_COLS; col++) begin
            read_cell(row, col, data);
            check_value($sformatf("%s row %0d col %0d", test, row, col),
                        expected_cell(row, col), data);
         end
      end
   endtask

   `include "tb_console_tests.svh"

   // --------------------
   // Main sequence
   // --------------------
   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      pad1        = '0;
      pad2        = '0;
      pad1_snes   = 1'b0;
      pad2_snes   = 1'b0;
      mouse       = '0;
      sram_test   = '0;
      sdram_test  = '0;
      sd_test     = '0;
      read_addr   = '0;
      error_count = 0;
      check_count = 0;
      lfsr        = 32'h78ba_9b63;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;

      clear_after_reset();
      pad1_fields();
      pad2_fields();
      mouse_field();
      memory_status();

      $display("%0d errors in %0d checks", error_count, check_count);
      if (error_count == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (LIMIT_CYCLES) @(posedge clk);
      $display("Timeout after %0d cycles, the scanner stopped producing passes", LIMIT_CYCLES);
      $display("tests failed");
      $finish;
   end

endmodule

/* hw/status_console.sv */
`timescale 1ns/10ps

module status_console
   import console_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  pad_state_t             pad1,
   input  pad_state_t             pad2,
   input  logic                   pad1_snes,
   input  logic                   pad2_snes,
   input  mouse_state_t           mouse,
   input  mem_test_t              sram_test,
   input  mem_test_t              sdram_test,
   input  mem_test_t              sd_test,
   input  logic [CELL_ADDR_W-1:0] read_addr,
   output logic [7:0]             read_data,
   output logic                   pass_done
);

   tty_byte_u              tty_byte;
   logic                   tty_we;
   logic                   busy;
   logic [CELL_ADDR_W-1:0] wr_addr;
   logic [7:0]             wr_data;
   logic                   wr_en;

   status_scanner i_status_scanner (
      .clk        (clk),
      .rst_n      (rst_n),
      .pad1       (pad1),
      .pad2       (pad2),
      .pad1_snes  (pad1_snes),
      .pad2_snes  (pad2_snes),
      .mouse      (mouse),
      .sram_test  (sram_test),
      .sdram_test (sdram_test),
      .sd_test    (sd_test),
      .busy       (busy),
      .tty_byte   (tty_byte),
      .tty_we     (tty_we),
      .pass_done  (pass_done)
   );

   teletype i_teletype (
      .clk      (clk),
      .rst_n    (rst_n),
      .tty_byte (tty_byte),
      .tty_we   (tty_we),
      .busy     (busy),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .wr_en    (wr_en)
   );

   screen_buffer i_screen_buffer (
      .clk       (clk),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .read_addr (read_addr),
      .read_data (read_data)
   );

endmodule

/* hw/status_scanner.sv */
`timescale 1ns/10ps

module status_scanner
   import console_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  pad_state_t   pad1,
   input  pad_state_t   pad2,
   input  logic         pad1_snes,
   input  logic         pad2_snes,
   input  mouse_state_t mouse,
   input  mem_test_t    sram_test,
   input  mem_test_t    sdram_test,
   input  mem_test_t    sd_test,
   input  logic         busy,
   output tty_byte_u    tty_byte,
   output logic         tty_we,
   output logic         pass_done
);

   typedef enum logic [2:0] {
      S_HOME,
      S_FORMAT,
      S_LOAD,
      S_SEND,
      S_HOLD
   } scan_state_e;

   scan_state_e state;
   logic [2:0]  fidx;      // Current field
   logic [3:0]  step;      // 0 AT, 1 row, 2 col, then text
   logic        homed;
   line_t       line_q;
   line_t       text;
   logic [4:0]  field_row;
   logic [3:0]  field_len;
   logic [3:0]  last_step;

   // --------------------
   // Text formatting
   // --------------------
   function automatic logic [7:0] flag_char(logic set, logic [7:0] letter);
      return set ? letter : CHAR_BLANK;
   endfunction

   function automatic logic [7:0] hex_char(logic [3:0] nib);
      return (nib < 4'd10) ? (8'h30 + 8'(nib)) : (8'h37 + 8'(nib));
   endfunction

   function automatic line_t pad_line_a(pad_state_t p, logic snes);
      return {flag_char(p.up, "U"), flag_char(p.down, "D"),
              flag_char(p.left, "L"), flag_char(p.right, "R"),
              flag_char(p.a, "A"), flag_char(p.b, "B"), flag_char(p.c, "C"),
              CHAR_BLANK,
              snes ? "SNES" : {4{CHAR_BLANK}}};
   endfunction

   function automatic line_t pad_line_b(pad_state_t p);
      return {flag_char(p.x, "X"), flag_char(p.y, "Y"), flag_char(p.z, "Z"),
              CHAR_BLANK,
              flag_char(p.start, "S"), flag_char(p.mode, "M"),
              {6{CHAR_BLANK}}};
   endfunction

   function automatic line_t mem_line(mem_test_t t);
      if (t.in_progress)
         return {"wait ", {7{CHAR_BLANK}}};
      else if (t.passed)
         return {"OK   ", {7{CHAR_BLANK}}};
      else
         return {"ERROR", {7{CHAR_BLANK}}};
   endfunction

   function automatic line_t mouse_line(mouse_state_t m);
      return {hex_char(m.x[7:4]), hex_char(m.x[3:0]), CHAR_BLANK,
              hex_char(m.y[7:4]), hex_char(m.y[3:0]), CHAR_BLANK,
              flag_char(m.buttons.left, "L"),
              flag_char(m.buttons.middle, "M"),
              flag_char(m.buttons.right, "R"),
              {3{CHAR_BLANK}}};
   endfunction

   always_comb begin
      text      = {LINE_MAX{CHAR_BLANK}};
      field_row = ROW_PAD1_A;
      field_len = LEN_PAD_A;
      case (fidx)
         FLD_PAD1_A: begin
            text      = pad_line_a(pad1, pad1_snes);
            field_row = ROW_PAD1_A;
            field_len = LEN_PAD_A;
         end
         FLD_PAD1_B: begin
            text      = pad_line_b(pad1);
            field_row = ROW_PAD1_B;
            field_len = LEN_PAD_B;
         end
         FLD_PAD2_A: begin
            text      = pad_line_a(pad2, pad2_snes);
            field_row = ROW_PAD2_A;
            field_len = LEN_PAD_A;
         end
         FLD_PAD2_B: begin
            text      = pad_line_b(pad2);
            field_row = ROW_PAD2_B;
            field_len = LEN_PAD_B;
         end
         FLD_SRAM: begin
            text      = mem_line(sram_test);
            field_row = ROW_SRAM;
            field_len = LEN_MEM;
         end
         FLD_SDRAM: begin
            text      = mem_line(sdram_test);
            field_row = ROW_SDRAM;
            field_len = LEN_MEM;
         end
         FLD_SD: begin
            text      = mem_line(sd_test);
            field_row = ROW_SD;
            field_len = LEN_MEM;
         end
         FLD_MOUSE: begin
            text      = mouse_line(mouse);
            field_row = ROW_MOUSE;
            field_len = LEN_MOUSE;
         end
         default: ;
      endcase
   end

   assign last_step = field_len + 4'd2;

   // --------------------
   // Sequencer
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= S_HOME;
         fidx      <= '0;
         step      <= '0;
         homed     <= 1'b0;
         tty_we    <= 1'b0;
         pass_done <= 1'b0;
      end else begin
         pass_done <= 1'b0;
         case (state)
            S_HOME:   state <= S_SEND;
            S_FORMAT: state <= S_LOAD;
            S_LOAD:   state <= S_SEND;
            S_SEND: begin
               if (!busy) begin
                  tty_we <= 1'b1;
                  state  <= S_HOLD;
               end
            end
            S_HOLD: begin
               tty_we <= 1'b0;
               if (!homed) begin
                  homed <= 1'b1;
                  state <= S_FORMAT;
               end else if (step == last_step) begin
                  step  <= '0;
                  state <= S_FORMAT;
                  if (fidx == 3'(FIELD_COUNT - 1)) begin
                     fidx      <= '0;
                     pass_done <= 1'b1;  // Last byte of the pass accepted
                  end else begin
                     fidx <= fidx + 3'd1;
                  end
               end else begin
                  step  <= step + 4'd1;
                  state <= S_LOAD;
               end
            end
            default: state <= S_HOME;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      case (state)
         S_HOME:   tty_byte.code <= CMD_HOME;
         S_FORMAT: line_q <= text;  // Inputs sampled here
         S_LOAD: begin
            case (step)
               4'd0:    tty_byte.code  <= CMD_AT;
               4'd1:    tty_byte.coord <= '{unused: 3'b000, value: field_row};
               4'd2:    tty_byte.coord <= '{unused: 3'b000, value: FIELD_COL};
               default: tty_byte.code  <= line_q[step - 4'd3];
            endcase
         end
         default: ;
      endcase
   end

   // One-cycle strobes only
   assert property (@(posedge clk) disable iff (!rst_n) tty_we |=> !tty_we);

endmodule

/* hw/teletype.sv */
`timescale 1ns/10ps

module teletype
   import console_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  tty_byte_u              tty_byte,
   input  logic                   tty_we,
   output logic                   busy,
   output logic [CELL_ADDR_W-1:0] wr_addr,
   output logic [7:0]             wr_data,
   output logic                   wr_en
);

   typedef enum logic [2:0] {
      T_IDLE,
      T_DECODE,
      T_AT_ROW,
      T_AT_COL,
      T_CLEAR,
      T_PUT
   } tty_state_e;

   tty_state_e             state;
   tty_byte_u              cmd;     // Byte under decode
   logic [4:0]             at_row;
   logic [CELL_ADDR_W-1:0] cursor;

   assign wr_addr = cursor;

   // --------------------
   // Command FSM
   // --------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= T_IDLE;
         busy   <= 1'b0;
         wr_en  <= 1'b0;
         cursor <= '0;
      end else begin
         case (state)
            T_IDLE: begin
               if (tty_we) begin
                  busy  <= 1'b1;
                  state <= T_DECODE;
               end
            end
            T_DECODE: begin
               if (cmd.code == CMD_AT) begin
                  state <= T_AT_ROW;
               end else if (cmd.code == CMD_HOME) begin
                  cursor <= '0;
                  wr_en  <= 1'b1;
                  state  <= T_CLEAR;
               end else begin
                  state <= T_PUT;
               end
            end
            T_AT_ROW: begin
               if (busy)
                  busy <= 1'b0;  // Second busy cycle of AT
               else if (tty_we)
                  state <= T_AT_COL;
            end
            T_AT_COL: begin
               if (tty_we) begin
                  cursor <= CELL_ADDR_W'(at_row * SCREEN_COLS)
                            + CELL_ADDR_W'(tty_byte.coord.value);
                  state  <= T_IDLE;
               end
            end
            T_CLEAR: begin
               if (cursor == LAST_CELL) begin
                  wr_en  <= 1'b0;
                  busy   <= 1'b0;
                  cursor <= '0;
                  state  <= T_IDLE;
               end else begin
                  cursor <= cursor + CELL_ADDR_W'(1);
               end
            end
            T_PUT: begin
               if (!wr_en) begin
                  wr_en <= 1'b1;
               end else begin
                  wr_en  <= 1'b0;
                  busy   <= 1'b0;
                  cursor <= cursor + CELL_ADDR_W'(1);  // Wraps at 512
                  state  <= T_IDLE;
               end
            end
            default: state <= T_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == T_IDLE && tty_we)
         cmd <= tty_byte;
      if (state == T_AT_ROW && !busy && tty_we)
         at_row <= tty_byte.coord.value;
      if (state == T_DECODE)
         wr_data <= (cmd.code == CMD_HOME) ? CHAR_BLANK : cmd.code;
   end

   // Scanner must honour busy
   assert property (@(posedge clk) disable iff (!rst_n) busy |-> !tty_we);

endmodule

/* hw/screen_buffer.sv */
`timescale 1ns/10ps

module screen_buffer
   import console_pkg::*;
(
   input  logic                   clk,
   input  logic                   wr_en,
   input  logic [CELL_ADDR_W-1:0] wr_addr,
   input  logic [7:0]             wr_data,
   input  logic [CELL_ADDR_W-1:0] read_addr,
   output logic [7:0]             read_data
);

   // One byte per character cell, row major
   logic [7:0] mem [SCREEN_ROWS*SCREEN_COLS];

   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   // Display side, one cycle latency
   always_ff @(posedge clk) begin
      read_data <= mem[read_addr];
   end

   assert property (@(posedge clk) wr_en |-> !$isunknown(wr_addr));

endmodule

/* hw/console_pkg.sv */
package console_pkg;

   // --------------------
   // Screen geometry
   // --------------------
   localparam int SCREEN_COLS = 32;
   localparam int SCREEN_ROWS = 16;
   localparam int CELL_COUNT  = 512;
   localparam int CELL_ADDR_W = 9;

   localparam logic [CELL_ADDR_W-1:0] LAST_CELL = CELL_ADDR_W'(CELL_COUNT - 1);

   // Teletype command codes
   localparam logic [7:0] CMD_AT     = 8'd22;
   localparam logic [7:0] CMD_HOME   = 8'd12;
   localparam logic [7:0] CHAR_BLANK = 8'h20;

   // --------------------
   // Field layout
   // --------------------
   localparam logic [4:0] FIELD_COL  = 5'd18;
   localparam logic [4:0] ROW_PAD1_A = 5'd3;
   localparam logic [4:0] ROW_PAD1_B = 5'd4;
   localparam logic [4:0] ROW_PAD2_A = 5'd5;
   localparam logic [4:0] ROW_PAD2_B = 5'd6;
   localparam logic [4:0] ROW_SRAM   = 5'd7;
   localparam logic [4:0] ROW_SDRAM  = 5'd8;
   localparam logic [4:0] ROW_SD     = 5'd9;
   localparam logic [4:0] ROW_MOUSE  = 5'd10;

   localparam int FIELD_COUNT = 8;

   // Scan order
   localparam logic [2:0] FLD_PAD1_A = 3'd0;
   localparam logic [2:0] FLD_PAD1_B = 3'd1;
   localparam logic [2:0] FLD_PAD2_A = 3'd2;
   localparam logic [2:0] FLD_PAD2_B = 3'd3;
   localparam logic [2:0] FLD_SRAM   = 3'd4;
   localparam logic [2:0] FLD_SDRAM  = 3'd5;
   localparam logic [2:0] FLD_SD     = 3'd6;
   localparam logic [2:0] FLD_MOUSE  = 3'd7;

   // Characters per field
   localparam int LINE_MAX      = 12;
   localparam logic [3:0] LEN_PAD_A = 4'd12;
   localparam logic [3:0] LEN_PAD_B = 4'd6;
   localparam logic [3:0] LEN_MEM   = 4'd5;
   localparam logic [3:0] LEN_MOUSE = 4'd9;

   typedef logic [0:LINE_MAX-1][7:0] line_t;  // Element 0 is the leftmost char

   // --------------------
   // Status types
   // --------------------
   typedef struct packed {
      logic mode;
      logic x;
      logic y;
      logic z;
      logic start;
      logic a;
      logic up;
      logic down;
      logic left;
      logic right;
      logic b;
      logic c;
   } pad_state_t;

   typedef struct packed {
      logic in_progress;
      logic passed;
   } mem_test_t;

   typedef struct packed {
      logic left;
      logic right;
      logic middle;
   } mouse_buttons_t;

   typedef struct packed {
      mouse_buttons_t buttons;
      logic [7:0]     x;
      logic [7:0]     y;
   } mouse_state_t;

   // Byte after AT carries a row or column in the low bits
   typedef struct packed {
      logic [2:0] unused;
      logic [4:0] value;
   } tty_coord_t;

   typedef union packed {
      logic [7:0] code;
      tty_coord_t coord;
   } tty_byte_u;

endpackage
